// File: source/panel_macros.svh
// Panel geometry macros
// sizes of the 64x32 frame RAM, its address fields and the brightness planes
`ifndef PANEL_MACROS_SVH
`define PANEL_MACROS_SVH

`define PANEL_ROWS 32
`define PANEL_COLS 64

// two bytes per pixel
`define ROW_BITS 5
`define COL_BITS 6
`define BYTE_SEL_BITS 1
`define RAM_ADDR_BITS 12

`define DATA_BITS 8
`define BRIGHTNESS_LEVELS 6

`endif

// File: source/panel_geometry_pkg.sv
// Panel geometry types
// frame RAM address fields, pixel bytes and brightness plane enables
`include "panel_macros.svh"

package panel_geometry_pkg;

    typedef logic [`ROW_BITS-1:0] row_addr_t;
    typedef logic [`COL_BITS-1:0] col_addr_t;
    typedef logic [`BYTE_SEL_BITS-1:0] byte_sel_t;

    // {row, col, byte select}, row in the top bits
    typedef logic [`RAM_ADDR_BITS-1:0] ram_addr_t;

    typedef logic [`DATA_BITS-1:0] pixel_byte_t;
    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_t;

endpackage

// File: source/command_pkg.sv
// Command set of the matrix controller
// ASCII opcodes, decoder states and the operations sent to the settings block
package command_pkg;

    typedef enum logic [7:0] {
        opc_red_on          = "R",
        opc_red_off         = "r",
        opc_green_on        = "G",
        opc_green_off       = "g",
        opc_blue_on         = "B",
        opc_blue_off        = "b",
        opc_plane_1         = "1",
        opc_plane_2         = "2",
        opc_plane_3         = "3",
        opc_plane_4         = "4",
        opc_plane_5         = "5",
        opc_plane_6         = "6",
        opc_all_off         = "0",
        opc_all_on          = "9",
        opc_load_brightness = "T",
        opc_pixel           = "P",
        opc_blank           = "Z"
    } cmd_opcode_t;

    typedef enum logic [1:0] {
        st_idle,
        st_read_brightness,
        st_read_pixel,
        st_blank
    } ctrl_state_t;

    typedef enum logic [3:0] {
        op_none,
        op_red_on,
        op_red_off,
        op_green_on,
        op_green_off,
        op_blue_on,
        op_blue_off,
        op_toggle_plane,
        op_all_off,
        op_all_on,
        op_load
    } setting_op_t;

endpackage

// File: source/command_decoder.sv
// Command decoder
// latches received bytes and dispatches them to settings, pixel writer and blanker
`timescale 1ns/10ps

module command_decoder
    import panel_geometry_pkg::*;
    import command_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  pixel_byte_t data_rx,
    input  logic        data_ready_n,
    input  logic        write_pending,
    input  logic        pixel_done,
    input  logic        blank_active,
    input  logic        blank_done,
    output setting_op_t setting_op,
    output pixel_byte_t setting_arg,
    output logic        arg_valid,
    output pixel_byte_t arg_byte,
    output logic        blank_start,
    output logic        busy,
    output logic        ready_for_data
);

    ctrl_state_t state;
    pixel_byte_t rx_byte;
    logic        rx_valid;
    logic        accept;

    assign accept = ~data_ready_n && ready_for_data;
    assign ready_for_data = ~(blank_active || write_pending);
    assign busy = (state != st_idle);

    // received byte and argument data
    always_ff @(posedge clk_in) begin
        if (accept) begin
            rx_byte <= data_rx;
        end
        if (rx_valid) begin
            arg_byte <= rx_byte;
            // digits carry the plane index and T carries the raw byte
            setting_arg <= (state == st_read_brightness) ? rx_byte : rx_byte - 8'h30;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state       <= st_idle;
            rx_valid    <= 1'b0;
            setting_op  <= op_none;
            arg_valid   <= 1'b0;
            blank_start <= 1'b0;
        end else begin
            rx_valid    <= accept;
            setting_op  <= op_none;
            arg_valid   <= 1'b0;
            blank_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_valid) begin
                        case (cmd_opcode_t'(rx_byte))
                            opc_red_on:    setting_op <= op_red_on;
                            opc_red_off:   setting_op <= op_red_off;
                            opc_green_on:  setting_op <= op_green_on;
                            opc_green_off: setting_op <= op_green_off;
                            opc_blue_on:   setting_op <= op_blue_on;
                            opc_blue_off:  setting_op <= op_blue_off;
                            opc_plane_1, opc_plane_2, opc_plane_3,
                            opc_plane_4, opc_plane_5, opc_plane_6: begin
                                setting_op <= op_toggle_plane;
                            end
                            opc_all_off:         setting_op <= op_all_off;
                            opc_all_on:          setting_op <= op_all_on;
                            opc_load_brightness: state <= st_read_brightness;
                            opc_pixel:           state <= st_read_pixel;
                            opc_blank: begin
                                state       <= st_blank;
                                blank_start <= 1'b1;
                            end
                            // unknown bytes are dropped
                            default: ;
                        endcase
                    end
                end
                st_read_brightness: begin
                    if (rx_valid) begin
                        setting_op <= op_load;
                        state      <= st_idle;
                    end
                end
                st_read_pixel: begin
                    arg_valid <= rx_valid;
                    if (pixel_done) begin
                        state <= st_idle;
                    end
                end
                st_blank: begin
                    if (blank_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: source/panel_settings.sv
// Panel settings
// colour-plane enables and brightness planes, the latter staged through a shadow
`timescale 1ns/10ps
`include "panel_macros.svh"

module panel_settings
    import panel_geometry_pkg::*;
    import command_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  setting_op_t setting_op,
    input  pixel_byte_t setting_arg,
    output logic [2:0]  rgb_enable,
    output brightness_t brightness_enable
);

    brightness_t brightness_shadow;
    brightness_t toggle_mask;

    // plane n sits at bit LEVELS - n
    assign toggle_mask = brightness_t'(1) << (`BRIGHTNESS_LEVELS - setting_arg);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable        <= 3'b111;
            brightness_shadow <= '1;
            brightness_enable <= '1;
        end else begin
            brightness_enable <= brightness_shadow;
            case (setting_op)
                op_red_on:    rgb_enable[0] <= 1'b1;
                op_red_off:   rgb_enable[0] <= 1'b0;
                op_green_on:  rgb_enable[1] <= 1'b1;
                op_green_off: rgb_enable[1] <= 1'b0;
                op_blue_on:   rgb_enable[2] <= 1'b1;
                op_blue_off:  rgb_enable[2] <= 1'b0;
                op_toggle_plane: begin
                    // toggle against what is displayed now
                    brightness_shadow <= (brightness_shadow & ~toggle_mask)
                                       | (~brightness_enable & toggle_mask);
                end
                op_all_off: brightness_shadow <= '0;
                op_all_on:  brightness_shadow <= '1;
                op_load:    brightness_shadow <= setting_arg[`BRIGHTNESS_LEVELS-1:0];
                default: ;
            endcase
        end
    end

endmodule

// File: source/pixel_writer.sv
// Single pixel writer
// gathers row, column and two colour bytes, then writes both bytes of the pixel
`timescale 1ns/10ps
`include "panel_macros.svh"

module pixel_writer
    import panel_geometry_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic        arg_valid,
    input  pixel_byte_t arg_byte,
    output logic        wr_req,
    output ram_addr_t   wr_addr,
    output pixel_byte_t wr_data,
    output logic        write_pending,
    output logic        pixel_done
);

    logic [1:0]  arg_count;
    logic        write_hi;
    logic        write_lo;
    row_addr_t   row;
    col_addr_t   col;
    pixel_byte_t data_hi;
    pixel_byte_t data_lo;
    byte_sel_t   byte_sel;

    always_ff @(posedge clk_in) begin
        if (arg_valid) begin
            case (arg_count)
                2'd0:    row     <= arg_byte[`ROW_BITS-1:0];
                2'd1:    col     <= arg_byte[`COL_BITS-1:0];
                2'd2:    data_hi <= arg_byte;
                default: data_lo <= arg_byte;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_count <= 2'd0;
            write_hi  <= 1'b0;
            write_lo  <= 1'b0;
        end else begin
            if (arg_valid) begin
                arg_count <= arg_count + 2'd1;
            end
            // high byte first, low byte on the next cycle
            write_hi <= arg_valid && (arg_count == 2'd3);
            write_lo <= write_hi;
        end
    end

    assign byte_sel      = write_lo ? byte_sel_t'(1) : byte_sel_t'(0);
    assign wr_req        = write_hi || write_lo;
    assign wr_addr       = {row, col, byte_sel};
    assign wr_data       = write_lo ? data_lo : data_hi;
    assign pixel_done    = write_lo;
    assign write_pending = write_hi || write_lo || (arg_valid && (arg_count == 2'd3));

endmodule

// File: source/panel_blanker.sv
// Panel blanker
// walks the whole frame RAM, one address per cycle, requesting zero writes
`timescale 1ns/10ps
`include "panel_macros.svh"

module panel_blanker
    import panel_geometry_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset,
    input  logic      blank_start,
    output logic      wr_req,
    output ram_addr_t wr_addr,
    output logic      blank_active,
    output logic      blank_done
);

    localparam ram_addr_t LAST_ADDR =
        ram_addr_t'(`PANEL_ROWS * `PANEL_COLS * (1 << `BYTE_SEL_BITS) - 1);

    ram_addr_t addr;
    logic      active;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active <= 1'b0;
            addr   <= '0;
        end else if (blank_start) begin
            active <= 1'b1;
            addr   <= '0;
        end else if (active) begin
            addr <= addr + ram_addr_t'(1);
            if (addr == LAST_ADDR) begin
                active <= 1'b0;
            end
        end
    end

    assign wr_req       = active;
    assign wr_addr      = addr;
    assign blank_active = active;
    assign blank_done   = active && (addr == LAST_ADDR);

endmodule

// File: source/ram_write_port.sv
// Frame RAM write port
// picks the active writer and registers the RAM write signals
`timescale 1ns/10ps

module ram_write_port
    import panel_geometry_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic        pix_req,
    input  ram_addr_t   pix_addr,
    input  pixel_byte_t pix_data,
    input  logic        blank_req,
    input  ram_addr_t   blank_addr,
    output ram_addr_t   ram_address,
    output pixel_byte_t ram_data_out,
    output logic        ram_write_enable
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
        end else begin
            ram_write_enable <= blank_req || pix_req;
        end
    end

    // blanker has priority and always writes zero
    always_ff @(posedge clk_in) begin
        ram_address  <= blank_req ? blank_addr : pix_addr;
        ram_data_out <= blank_req ? '0 : pix_data;
    end

endmodule

// File: source/matrix_control.sv
// RGB LED matrix command controller
// decoder, executors and RAM write port in a three stage pipeline
`timescale 1ns/10ps

module matrix_control
    import panel_geometry_pkg::*;
    import command_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  pixel_byte_t data_rx,
    input  logic        data_ready_n,
    output logic [2:0]  rgb_enable,
    output brightness_t brightness_enable,
    output pixel_byte_t ram_data_out,
    output ram_addr_t   ram_address,
    output logic        ram_write_enable,
    output logic        busy,
    output logic        ready_for_data
);

    setting_op_t setting_op;
    pixel_byte_t setting_arg;
    logic        arg_valid;
    pixel_byte_t arg_byte;
    logic        blank_start;
    logic        blank_active;
    logic        blank_done;
    logic        write_pending;
    logic        pixel_done;
    logic        pix_req;
    ram_addr_t   pix_addr;
    pixel_byte_t pix_data;
    logic        blank_req;
    ram_addr_t   blank_addr;

    command_decoder command_decoder_inst (
        .clk_in         (clk_in),
        .reset          (reset),
        .data_rx        (data_rx),
        .data_ready_n   (data_ready_n),
        .write_pending  (write_pending),
        .pixel_done     (pixel_done),
        .blank_active   (blank_active),
        .blank_done     (blank_done),
        .setting_op     (setting_op),
        .setting_arg    (setting_arg),
        .arg_valid      (arg_valid),
        .arg_byte       (arg_byte),
        .blank_start    (blank_start),
        .busy           (busy),
        .ready_for_data (ready_for_data)
    );

    panel_settings panel_settings_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .setting_op        (setting_op),
        .setting_arg       (setting_arg),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    pixel_writer pixel_writer_inst (
        .clk_in        (clk_in),
        .reset         (reset),
        .arg_valid     (arg_valid),
        .arg_byte      (arg_byte),
        .wr_req        (pix_req),
        .wr_addr       (pix_addr),
        .wr_data       (pix_data),
        .write_pending (write_pending),
        .pixel_done    (pixel_done)
    );

    panel_blanker panel_blanker_inst (
        .clk_in       (clk_in),
        .reset        (reset),
        .blank_start  (blank_start),
        .wr_req       (blank_req),
        .wr_addr      (blank_addr),
        .blank_active (blank_active),
        .blank_done   (blank_done)
    );

    ram_write_port ram_write_port_inst (
        .clk_in           (clk_in),
        .reset            (reset),
        .pix_req          (pix_req),
        .pix_addr         (pix_addr),
        .pix_data         (pix_data),
        .blank_req        (blank_req),
        .blank_addr       (blank_addr),
        .ram_address      (ram_address),
        .ram_data_out     (ram_data_out),
        .ram_write_enable (ram_write_enable)
    );

endmodule

// File: tests/matrix_control_tb.sv
// Testbench for the matrix command controller
// table-driven commands, RAM write monitor, settings and handshake checks
`timescale 1ns/10ps
`include "panel_macros.svh"

module matrix_control_tb;

    localparam int MAX_ENTRIES  = 64;
    localparam int BLANK_WRITES = `PANEL_ROWS * `PANEL_COLS * 2;
    localparam int CHK_RGB      = 0;
    localparam int CHK_BRIGHT   = 1;
    localparam int CHK_BUSY     = 2;
    localparam int CHK_IDLE     = 3;
    localparam int CHK_BLANK    = 4;

    logic                          clk_in;
    logic                          reset;
    logic [`DATA_BITS-1:0]         data_rx;
    logic                          data_ready_n;
    logic [2:0]                    rgb_enable;
    logic [`BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [`DATA_BITS-1:0]         ram_data_out;
    logic [`RAM_ADDR_BITS-1:0]     ram_address;
    logic                          ram_write_enable;
    logic                          busy;
    logic                          ready_for_data;

    // stimulus byte, check kind, expected value, writes expected so far
    logic [7:0]  tbl_byte [0:MAX_ENTRIES-1];
    int          tbl_kind [0:MAX_ENTRIES-1];
    logic [31:0] tbl_exp [0:MAX_ENTRIES-1];
    int          tbl_writes [0:MAX_ENTRIES-1];
    int          tbl_len;
    int          total_writes;

    // {address, data}
    logic [19:0]                   exp_writes [$];
    logic [19:0]                   next_write;
    int                            write_count = 0;
    int                            cycle_count = 0;
    int                            timeout_limit = 0;
    integer                        seed;
    logic [2:0]                    rgb_model;
    logic [`BRIGHTNESS_LEVELS-1:0] bright_model;

    matrix_control matrix_control_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_data_out      (ram_data_out),
        .ram_address       (ram_address),
        .ram_write_enable  (ram_write_enable),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    task automatic add_entry(input logic [7:0] b, input int kind,
                             input logic [31:0] expected, input int writes);
        total_writes         = total_writes + writes;
        tbl_byte[tbl_len]    = b;
        tbl_kind[tbl_len]    = kind;
        tbl_exp[tbl_len]     = expected;
        tbl_writes[tbl_len]  = total_writes;
        tbl_len              = tbl_len + 1;
    endtask

    task automatic add_setting(input logic [7:0] cmd);
        int kind;
        int plane;
        kind  = CHK_RGB;
        plane = int'(cmd) - 48;
        case (cmd)
            "R": rgb_model[0] = 1'b1;
            "r": rgb_model[0] = 1'b0;
            "G": rgb_model[1] = 1'b1;
            "g": rgb_model[1] = 1'b0;
            "B": rgb_model[2] = 1'b1;
            "b": rgb_model[2] = 1'b0;
            "0": begin
                bright_model = '0;
                kind         = CHK_BRIGHT;
            end
            "9": begin
                bright_model = '1;
                kind         = CHK_BRIGHT;
            end
            default: begin
                // plane n counts from the top bit
                bright_model = bright_model
                             ^ (`BRIGHTNESS_LEVELS'(1) << (`BRIGHTNESS_LEVELS - plane));
                kind         = CHK_BRIGHT;
            end
        endcase
        if (kind == CHK_RGB) begin
            add_entry(cmd, kind, 32'(rgb_model), 0);
        end else begin
            add_entry(cmd, kind, 32'(bright_model), 0);
        end
    endtask

    task automatic add_load();
        logic [31:0] rnd;
        rnd          = $random(seed);
        bright_model = rnd[`BRIGHTNESS_LEVELS-1:0];
        add_entry("T", CHK_BUSY, 32'd1, 0);
        add_entry(rnd[7:0], CHK_BRIGHT, 32'(bright_model), 0);
    endtask

    task automatic add_pixel();
        logic [31:0] rnd;
        rnd = $random(seed);
        add_entry("P", CHK_BUSY, 32'd1, 0);
        add_entry(rnd[7:0], CHK_BUSY, 32'd1, 0);
        add_entry(rnd[15:8], CHK_BUSY, 32'd1, 0);
        add_entry(rnd[23:16], CHK_BUSY, 32'd1, 0);
        add_entry(rnd[31:24], CHK_BUSY, 32'd0, 2);
        // high byte at select 0, low byte at select 1
        exp_writes.push_back({rnd[`ROW_BITS-1:0], rnd[8 +: `COL_BITS], 1'b0, rnd[23:16]});
        exp_writes.push_back({rnd[`ROW_BITS-1:0], rnd[8 +: `COL_BITS], 1'b1, rnd[31:24]});
    endtask

    task automatic add_blank();
        add_entry("Z", CHK_BLANK, 32'd0, BLANK_WRITES);
        for (int a = 0; a < BLANK_WRITES; a++) begin
            exp_writes.push_back({12'(a), 8'h00});
        end
    endtask

    task automatic build_table();
        rgb_model    = 3'b111;
        bright_model = '1;
        tbl_len      = 0;
        total_writes = 0;
        add_setting("r");
        add_setting("g");
        add_setting("B");
        add_setting("b");
        add_setting("R");
        add_setting("G");
        add_setting("B");
        add_setting("1");
        add_setting("2");
        add_setting("3");
        add_setting("4");
        add_setting("5");
        add_setting("6");
        add_setting("3");
        add_setting("0");
        add_setting("9");
        add_setting("2");
        add_setting("5");
        add_load();
        add_pixel();
        // unknown bytes leave everything alone
        add_entry("x", CHK_IDLE, 32'({rgb_model, bright_model}), 0);
        add_entry(8'hA5, CHK_IDLE, 32'({rgb_model, bright_model}), 0);
        add_blank();
        add_pixel();
        add_setting("r");
    endtask

    task automatic apply_entry(input int i);
        logic        accepted;
        logic [31:0] exp_busy;
        accepted = 1'b0;
        data_rx      <= tbl_byte[i];
        data_ready_n <= 1'b0;
        // strobe stays low until the edge that takes the byte
        while (!accepted) begin
            @(negedge clk_in);
            accepted = ready_for_data;
            @(posedge clk_in);
        end
        data_ready_n <= 1'b1;
        if (tbl_kind[i] == CHK_BLANK) begin
            repeat (2) @(posedge clk_in);
            @(negedge clk_in);
            check_value("busy", 32'(busy), 32'd1);
            while (busy) begin
                check_value("ready_for_data", 32'(ready_for_data), 32'd0);
                @(negedge clk_in);
            end
        end
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        case (tbl_kind[i])
            CHK_RGB:    check_value("rgb_enable", 32'(rgb_enable), tbl_exp[i]);
            CHK_BRIGHT: check_value("brightness_enable", 32'(brightness_enable), tbl_exp[i]);
            CHK_IDLE:   check_value("settings", 32'({rgb_enable, brightness_enable}), tbl_exp[i]);
            default: ;
        endcase
        exp_busy = (tbl_kind[i] == CHK_BUSY) ? tbl_exp[i] : 32'd0;
        check_value("busy", 32'(busy), exp_busy);
        check_value("ready_for_data", 32'(ready_for_data), 32'd1);
        @(posedge clk_in);
        check_value("ram write count", write_count, tbl_writes[i]);
    endtask

    // RAM write monitor
    always @(negedge clk_in) begin
        if (!reset && ram_write_enable) begin
            if (exp_writes.size() == 0) begin
                stop_run($sformatf("RAM write to 0x%0h when no write was due", ram_address));
            end else begin
                next_write = exp_writes.pop_front();
                check_value("ram_address", 32'(ram_address), 32'(next_write[19:8]));
                check_value("ram_data_out", 32'(ram_data_out), 32'(next_write[7:0]));
                write_count = write_count + 1;
            end
        end
    end

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            stop_run($sformatf("Timeout: test did not finish within %0d cycles", timeout_limit));
        end
    end

    initial begin
        seed = 29;
        reset        <= 1'b1;
        data_rx      <= '0;
        data_ready_n <= 1'b1;
        build_table();
        timeout_limit = 20 * tbl_len + 2 * BLANK_WRITES;
        repeat (2) @(posedge clk_in);
        reset <= 1'b0;
        @(negedge clk_in);
        check_value("rgb_enable", 32'(rgb_enable), 32'h7);
        check_value("brightness_enable", 32'(brightness_enable), 32'h3f);
        check_value("busy", 32'(busy), 32'd0);
        check_value("ready_for_data", 32'(ready_for_data), 32'd1);
        check_value("ram_write_enable", 32'(ram_write_enable), 32'd0);
        @(posedge clk_in);
        for (int i = 0; i < tbl_len; i++) begin
            apply_entry(i);
        end
        if (write_count == total_writes && exp_writes.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_run("RAM writes still missing at the end of the test");
        end
    end

endmodule

// File: compile.f
+incdir+source
source/panel_geometry_pkg.sv
source/command_pkg.sv
source/command_decoder.sv
source/panel_settings.sv
source/pixel_writer.sv
source/panel_blanker.sv
source/ram_write_port.sv
source/matrix_control.sv
tests/matrix_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the matrix controller testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module matrix_control_tb \
    -o matrix_control_tb &&
./obj_dir/matrix_control_tb ||
{ echo "simulation build or run ended with an error"; exit 1; }
